/* Makefile */
VERILATOR ?= verilator
TOP ?= string_match_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
+incdir+verilog
verilog/string_match_pkg.sv
verilog/window_if.sv
verilog/pattern_store.sv
verilog/text_window.sv
verilog/shift_compare.sv
verilog/scan_control.sv
verilog/string_match_top.sv
tb/string_match_tb.sv

/* tb/string_match_tb.sv */
`timescale 1ns/1ns
`include "string_match_defines.svh"

module string_match_tb;

	localparam int klen = `SM_PATTERN_WIDTH;
	localparam int nkeys = `SM_NOS_KEY;
	localparam int no_skip = `SM_PATTERN_WIDTH - `SM_BLOCK + 1;
	localparam int total_text = 60 + 60 + 300 + 300 + 300;
	localparam int cycle_limit = total_text * 10 + 500;
	localparam logic [55:0] known_key = 56'h30221101233210; // Symbol 0 in the low nibble

	logic clk;
	logic reset;
	logic pattern_write;
	string_match_pkg::key_t pattern_key;
	string_match_pkg::index_t pattern_index;
	string_match_pkg::symbol_t pattern_symbol;
	logic text_valid;
	string_match_pkg::symbol_t text_symbol;
	logic text_ready;
	logic match_valid;
	string_match_pkg::key_t match_key;
	string_match_pkg::pos_t match_pos;

	string_match_pkg::symbol_t text_mem [300];
	string_match_pkg::symbol_t key_model [nkeys][klen];
	string_match_pkg::key_t exp_key [$];
	string_match_pkg::pos_t exp_pos [$];
	logic [15:0] lfsr;
	int errors = 0;
	int monitor_errors = 0;
	int test_errors = 0;
	int passed = 0;
	int failed = 0;
	int cycles = 0;
	int stalls = 0;

	string_match_top i_string_match_top (
		.clk (clk),
		.reset (reset),
		.pattern_write (pattern_write),
		.pattern_key (pattern_key),
		.pattern_index (pattern_index),
		.pattern_symbol (pattern_symbol),
		.text_valid (text_valid),
		.text_symbol (text_symbol),
		.text_ready (text_ready),
		.match_valid (match_valid),
		.match_key (match_key),
		.match_pos (match_pos)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin : watchdog
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not end within %0d cycles", cycle_limit);
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Random bits and reference model
	//////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	function automatic int next_bits(input int n);
		int v;
		v = 0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic bit key_at(input int k, input int pos);
		bit same;
		same = 1'b1;
		for (int i = 0; i < klen; i++) begin
			if (text_mem[pos + i] != key_model[k][i]) same = 1'b0;
		end
		return same;
	endfunction

	// Oldest block against key symbols j to j+2, smallest j wins
	function automatic int key_skip(input int k, input int pos);
		int skip;
		bit hit;
		skip = no_skip;
		for (int j = 1; j < no_skip; j++) begin
			hit = 1'b1;
			for (int b = 0; b < `SM_BLOCK; b++) begin
				if (text_mem[pos + b] != key_model[k][j + b]) hit = 1'b0;
			end
			if (hit && j < skip) skip = j;
		end
		return skip;
	endfunction

	task automatic predict_matches(input int len);
		int pos;
		int skip;
		pos = 0;
		while (pos + klen <= len) begin
			skip = no_skip;
			for (int k = 0; k < nkeys; k++) begin
				if (key_at(k, pos)) begin
					exp_key.push_back(string_match_pkg::key_t'(k));
					exp_pos.push_back(string_match_pkg::pos_t'(pos));
				end
				if (key_skip(k, pos) < skip) skip = key_skip(k, pos);
			end
			pos += skip;
		end
	endtask

	//////////////////////////////////////////////////
	// Drivers
	//////////////////////////////////////////////////

	task automatic apply_reset();
		reset = 1'b1;
		text_valid = 1'b0;
		pattern_write = 1'b0;
		exp_key.delete();
		exp_pos.delete();
		repeat (2) @(negedge clk);
		reset = 1'b0;
		@(negedge clk); // text_ready comes up
	endtask

	task automatic clear_keys();
		for (int k = 0; k < nkeys; k++) begin
			for (int i = 0; i < klen; i++) key_model[k][i] = '0;
		end
	endtask

	task automatic set_known_key(input int k);
		for (int i = 0; i < klen; i++) key_model[k][i] = known_key[4*i +: 4];
	endtask

	task automatic load_key(input int k);
		for (int i = 0; i < klen; i++) begin
			@(negedge clk);
			pattern_write = 1'b1;
			pattern_key = string_match_pkg::key_t'(k);
			pattern_index = string_match_pkg::index_t'(i);
			pattern_symbol = key_model[k][i];
		end
		@(negedge clk);
		pattern_write = 1'b0;
	endtask

	task automatic fill_text(input int len, input bit random_text);
		for (int i = 0; i < len; i++) begin
			text_mem[i] = random_text ? string_match_pkg::symbol_t'(next_bits(2)) :
				string_match_pkg::symbol_t'(9); // Filler outside every key
		end
	endtask

	task automatic plant(input int k, input int pos);
		for (int i = 0; i < klen; i++) text_mem[pos + i] = key_model[k][i];
	endtask

	task automatic send_text(input int len, input bit continuous);
		stalls = 0;
		for (int i = 0; i < len; i++) begin
			if (!continuous && next_bits(1) == 1) begin
				@(negedge clk);
				text_valid = 1'b0; // Idle gap
			end
			@(negedge clk);
			text_valid = 1'b1;
			text_symbol = text_mem[i];
			while (!text_ready) begin
				stalls++;
				@(negedge clk);
			end
		end
		@(negedge clk);
		text_valid = 1'b0;
		while (!text_ready) @(negedge clk); // Last scan still running
	endtask

	task automatic end_test(input int num, input string name, input int nmatch);
		assert (exp_key.size() == 0) else begin
			$display("%0d expected matches never came out", exp_key.size());
			errors++;
		end
		if (errors + monitor_errors == test_errors) begin
			passed++;
			$display("[%0d] %s: pass, %0d matches", num, name, nmatch);
		end else begin
			failed++;
			$display("[%0d] %s: fail, %0d errors", num, name, errors + monitor_errors - test_errors);
		end
		test_errors = errors + monitor_errors;
	endtask

	//////////////////////////////////////////////////
	// Match checks
	//////////////////////////////////////////////////

	always @(negedge clk) begin : check_match
		string_match_pkg::key_t k;
		string_match_pkg::pos_t p;
		if (!reset && match_valid) begin
			assert (exp_key.size() > 0) else begin
				$display("Unexpected match of key %0d at position %0d", match_key, match_pos);
				monitor_errors++;
			end
			if (exp_key.size() > 0) begin
				k = exp_key.pop_front();
				p = exp_pos.pop_front();
				assert (match_key == k) else begin
					$display("FAILED match_key: got 0x%h, expected 0x%h", match_key, k);
					monitor_errors++;
				end
				assert (match_pos == p) else begin
					$display("FAILED match_pos: got 0x%h, expected 0x%h", match_pos, p);
					monitor_errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial begin
		int nmatch;
		bit found;
		reset = 1'b1;
		pattern_write = 1'b0;
		pattern_key = '0;
		pattern_index = '0;
		pattern_symbol = '0;
		text_valid = 1'b0;
		text_symbol = '0;
		lfsr = 16'd47;

		apply_reset();
		repeat (10) begin
			@(negedge clk);
			assert (text_ready == 1'b1) else begin
				$display("FAILED text_ready: got 0x%h, expected 0x1", text_ready);
				errors++;
			end
			assert (match_valid == 1'b0) else begin
				$display("FAILED match_valid: got 0x%h, expected 0x0", match_valid);
				errors++;
			end
		end
		end_test(1, "idle after reset", 0);

		apply_reset();
		clear_keys();
		set_known_key(2);
		load_key(2);
		fill_text(60, 1'b0);
		plant(2, 36);
		predict_matches(60);
		assert (exp_key.size() == 1 && exp_key[0] == string_match_pkg::key_t'(2) &&
			exp_pos[0] == string_match_pkg::pos_t'(36)) else begin
			$display("Model does not expect one match of key 2 at position 36");
			errors++;
		end
		send_text(60, 1'b0);
		end_test(2, "single planted key", 1);

		apply_reset();
		clear_keys();
		set_known_key(1);
		set_known_key(3);
		load_key(1);
		load_key(3);
		fill_text(60, 1'b0);
		plant(1, 24);
		predict_matches(60);
		assert (exp_key.size() == 2 && exp_key[0] == string_match_pkg::key_t'(1) &&
			exp_key[1] == string_match_pkg::key_t'(3) && exp_pos[0] == exp_pos[1]) else begin
			$display("Model does not expect keys 1 and 3 in the same window");
			errors++;
		end
		send_text(60, 1'b0);
		end_test(4, "identical keys in one window", 2);

		apply_reset();
		for (int k = 0; k < nkeys; k++) begin
			for (int i = 0; i < klen; i++) begin
				key_model[k][i] = string_match_pkg::symbol_t'(next_bits(2));
			end
			load_key(k);
		end
		fill_text(300, 1'b1);
		plant(0, 40);
		plant(1, 120);
		plant(3, 200);
		predict_matches(300);
		nmatch = exp_key.size();
		send_text(300, 1'b0);
		end_test(3, "random text with gaps", nmatch);

		apply_reset();
		for (int k = 0; k < nkeys; k++) load_key(k);
		predict_matches(300);
		nmatch = exp_key.size();
		send_text(300, 1'b1);
		assert (stalls > 0) else begin
			$display("text_ready never dropped while text_valid was held high");
			errors++;
		end
		end_test(5, "random text, valid held high", nmatch);

		apply_reset();
		for (int k = 0; k < nkeys; k++) load_key(k);
		for (int i = 0; i < klen; i++) key_model[1][i] = text_mem[i]; // Key 1 becomes the first window
		load_key(1);
		predict_matches(300);
		found = 1'b0;
		foreach (exp_key[m]) begin
			if (exp_key[m] == string_match_pkg::key_t'(1) && exp_pos[m] == '0) found = 1'b1;
		end
		assert (found) else begin
			$display("Model does not expect the rewritten key at position 0");
			errors++;
		end
		nmatch = exp_key.size();
		send_text(300, 1'b0);
		end_test(6, "rewritten key", nmatch);

		$display("tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0 && errors + monitor_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* verilog/pattern_store.sv */
`timescale 1ns/1ns
`include "string_match_defines.svh"

module pattern_store (
	input logic clk,
	input logic reset,
	input logic pattern_write,
	input string_match_pkg::key_t pattern_key,
	input string_match_pkg::index_t pattern_index,
	input string_match_pkg::symbol_t pattern_symbol,
	output string_match_pkg::pattern_set_t patterns
);

	string_match_pkg::symbol_t key_mem [`SM_NOS_KEY][`SM_PATTERN_WIDTH];

	//////////////////////////////////////////////////
	// Symbol writes
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < `SM_NOS_KEY; k++) begin
				for (int i = 0; i < `SM_PATTERN_WIDTH; i++) begin
					key_mem[k][i] <= '0;
				end
			end
		end else if (pattern_write) begin
			if (pattern_index < `SM_PATTERN_WIDTH) begin // Indices 14 and 15 are dropped
				key_mem[pattern_key][pattern_index] <= pattern_symbol;
			end
		end
	end

	//////////////////////////////////////////////////
	// Flat read bus
	//////////////////////////////////////////////////

	for (genvar k = 0; k < `SM_NOS_KEY; k++) begin : g_key
		for (genvar i = 0; i < `SM_PATTERN_WIDTH; i++) begin : g_sym
			assign patterns[(k*`SM_PATTERN_WIDTH+i)*`SM_MSG_WIDTH +: `SM_MSG_WIDTH] =
				key_mem[k][i];
		end
	end

endmodule

/* verilog/scan_control.sv */
`timescale 1ns/1ns
`include "string_match_defines.svh"

module scan_control (
	input logic clk,
	input logic reset,
	window_if.scan win,
	input string_match_pkg::pos_t window_pos,
	output logic compare_enable,
	input string_match_pkg::shift_t shift_amount,
	input logic complete_match,
	output logic match_valid,
	output string_match_pkg::key_t match_key,
	output string_match_pkg::pos_t match_pos
);

	localparam int nos_shift = `SM_PATTERN_WIDTH - `SM_BLOCK + 1;

	string_match_pkg::scan_state_t state;
	string_match_pkg::key_t key_cnt;
	string_match_pkg::key_t res_key;
	string_match_pkg::shift_t min_skip;
	logic res_valid;
	logic last_key;

	assign last_key = (key_cnt == string_match_pkg::key_t'(`SM_NOS_KEY - 1));

	// Key 0 goes out in the cycle full is first seen
	assign compare_enable = (state == string_match_pkg::IDLE && win.full) ||
		(state == string_match_pkg::SCAN);

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= string_match_pkg::IDLE;
			key_cnt <= '0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= compare_enable; // Comparator result is one cycle late
			if (compare_enable) begin
				key_cnt <= key_cnt + 1'b1;
			end
			case (state)
				string_match_pkg::IDLE: begin
					if (win.full) begin
						state <= string_match_pkg::SCAN;
					end
				end
				string_match_pkg::SCAN: begin
					if (last_key) begin
						state <= string_match_pkg::DRAIN;
					end
				end
				string_match_pkg::DRAIN: begin
					state <= string_match_pkg::SHIFT; // Last result lands here
				end
				default: begin
					state <= string_match_pkg::IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Result tracking
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		res_key <= key_cnt;
		if (state == string_match_pkg::IDLE) begin
			min_skip <= string_match_pkg::shift_t'(nos_shift);
		end else if (res_valid && shift_amount < min_skip) begin
			min_skip <= shift_amount;
		end
	end

	assign match_valid = res_valid && complete_match;
	assign match_key = res_key;
	assign match_pos = window_pos; // Stable until the shift

	assign win.shift_strobe = (state == string_match_pkg::SHIFT);
	assign win.shift_count = min_skip;

endmodule

/* verilog/shift_compare.sv */
`timescale 1ns/1ns
`include "string_match_defines.svh"

module shift_compare (
	input logic clk,
	input logic reset,
	input logic compare_enable,
	input string_match_pkg::window_t data_in,
	input string_match_pkg::pattern_set_t patterns,
	output string_match_pkg::shift_t shift_amount,
	output logic complete_match
);

	localparam int key_bits = `SM_MSG_WIDTH * `SM_PATTERN_WIDTH;
	localparam int block_bits = `SM_MSG_WIDTH * `SM_BLOCK;
	localparam int nos_shift = `SM_PATTERN_WIDTH - `SM_BLOCK + 1;

	string_match_pkg::key_t sel;
	string_match_pkg::window_t pattern;
	logic [nos_shift-1:1] block_hit;
	string_match_pkg::shift_t skip;
	logic whole_hit;

	//////////////////////////////////////////////////
	// Key select
	//////////////////////////////////////////////////

	assign pattern = patterns[sel*key_bits +: key_bits];

	//////////////////////////////////////////////////
	// Block compare and skip
	//////////////////////////////////////////////////

	// Oldest three window symbols against key symbols j to j+2
	for (genvar j = 1; j < nos_shift; j++) begin : g_block
		assign block_hit[j] =
			(data_in[block_bits-1:0] == pattern[j*`SM_MSG_WIDTH +: block_bits]);
	end

	// Smallest hit offset wins
	always_comb begin
		skip = string_match_pkg::shift_t'(nos_shift); // Nothing found
		for (int j = nos_shift - 1; j >= 1; j--) begin
			if (block_hit[j]) begin
				skip = string_match_pkg::shift_t'(j);
			end
		end
	end

	assign whole_hit = (pattern == data_in);

	//////////////////////////////////////////////////
	// Result registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= '0;
			shift_amount <= '0;
			complete_match <= 1'b0;
		end else begin
			shift_amount <= skip;
			complete_match <= whole_hit;
			if (compare_enable) begin
				sel <= sel + 1'b1; // Wraps after the last key
			end
		end
	end

endmodule

/* verilog/string_match_defines.svh */
`ifndef STRING_MATCH_DEFINES_SVH
`define STRING_MATCH_DEFINES_SVH

//////////////////////////////////////////////////
// Scanner sizes
//////////////////////////////////////////////////

// Bits per text or key symbol
`define SM_MSG_WIDTH 4

// Symbols per key, also the text window length
`define SM_PATTERN_WIDTH 14

// Symbols in the skip test block
`define SM_BLOCK 3

// Keys in the store, power of two
`define SM_NOS_KEY 4

// Text position counter width
`define SM_POS_WIDTH 16

`endif

/* verilog/string_match_pkg.sv */
`include "string_match_defines.svh"

package string_match_pkg;

	//////////////////////////////////////////////////
	// Data widths
	//////////////////////////////////////////////////

	typedef logic [`SM_MSG_WIDTH-1:0] symbol_t;

	// Symbol 0 is the oldest, in the lowest bits
	typedef logic [`SM_MSG_WIDTH*`SM_PATTERN_WIDTH-1:0] window_t;

	// Key k sits in slice k
	typedef logic [`SM_MSG_WIDTH*`SM_PATTERN_WIDTH*`SM_NOS_KEY-1:0] pattern_set_t;

	typedef logic [$clog2(`SM_PATTERN_WIDTH-`SM_BLOCK+1):0] shift_t; // 0 to 12
	typedef logic [$clog2(`SM_NOS_KEY)-1:0] key_t;
	typedef logic [$clog2(`SM_PATTERN_WIDTH)-1:0] index_t;
	typedef logic [`SM_POS_WIDTH-1:0] pos_t;

	//////////////////////////////////////////////////
	// Scan sequencer
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		DRAIN,
		SHIFT
	} scan_state_t;

endpackage

/* verilog/string_match_top.sv */
`timescale 1ns/1ns

module string_match_top (
	input logic clk,
	input logic reset,
	input logic pattern_write,
	input string_match_pkg::key_t pattern_key,
	input string_match_pkg::index_t pattern_index,
	input string_match_pkg::symbol_t pattern_symbol,
	input logic text_valid,
	input string_match_pkg::symbol_t text_symbol,
	output logic text_ready,
	output logic match_valid,
	output string_match_pkg::key_t match_key,
	output string_match_pkg::pos_t match_pos
);

	string_match_pkg::pattern_set_t patterns;
	string_match_pkg::pos_t window_pos;
	string_match_pkg::shift_t shift_amount;
	logic compare_enable;
	logic complete_match;

	window_if i_window_if ();

	pattern_store i_pattern_store (
		.clk (clk),
		.reset (reset),
		.pattern_write (pattern_write),
		.pattern_key (pattern_key),
		.pattern_index (pattern_index),
		.pattern_symbol (pattern_symbol),
		.patterns (patterns)
	);

	text_window i_text_window (
		.clk (clk),
		.reset (reset),
		.text_valid (text_valid),
		.text_symbol (text_symbol),
		.text_ready (text_ready),
		.win (i_window_if.buffer),
		.window_pos (window_pos)
	);

	shift_compare i_shift_compare (
		.clk (clk),
		.reset (reset),
		.compare_enable (compare_enable),
		.data_in (i_window_if.window),
		.patterns (patterns),
		.shift_amount (shift_amount),
		.complete_match (complete_match)
	);

	scan_control i_scan_control (
		.clk (clk),
		.reset (reset),
		.win (i_window_if.scan),
		.window_pos (window_pos),
		.compare_enable (compare_enable),
		.shift_amount (shift_amount),
		.complete_match (complete_match),
		.match_valid (match_valid),
		.match_key (match_key),
		.match_pos (match_pos)
	);

endmodule

/* verilog/text_window.sv */
`timescale 1ns/1ns
`include "string_match_defines.svh"

module text_window (
	input logic clk,
	input logic reset,
	input logic text_valid,
	input string_match_pkg::symbol_t text_symbol,
	output logic text_ready,
	window_if.buffer win,
	output string_match_pkg::pos_t window_pos
);

	localparam int fill_w = $clog2(`SM_PATTERN_WIDTH + 1);

	logic [fill_w-1:0] fill;
	logic [fill_w-1:0] fill_next;
	string_match_pkg::window_t window_q;
	string_match_pkg::pos_t pos;
	logic take;

	assign take = text_valid && text_ready;

	assign win.window = window_q;
	assign win.full = (fill == fill_w'(`SM_PATTERN_WIDTH));
	assign window_pos = pos;

	//////////////////////////////////////////////////
	// Fill count and position
	//////////////////////////////////////////////////

	// A shift only comes while full, so it never meets a take
	always_comb begin
		fill_next = fill;
		if (win.shift_strobe) begin
			fill_next = fill - fill_w'(win.shift_count);
		end else if (take) begin
			fill_next = fill + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			fill <= '0;
			pos <= '0;
			text_ready <= 1'b0;
		end else begin
			fill <= fill_next;
			text_ready <= (fill_next != fill_w'(`SM_PATTERN_WIDTH)); // Low from the full edge on
			if (win.shift_strobe) begin
				pos <= pos + string_match_pkg::pos_t'(win.shift_count); // Tracks the oldest symbol
			end
		end
	end

	//////////////////////////////////////////////////
	// Window data
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (win.shift_strobe) begin
			window_q <= window_q >> (win.shift_count * `SM_MSG_WIDTH); // Oldest symbols fall out
		end else if (take) begin
			window_q[fill*`SM_MSG_WIDTH +: `SM_MSG_WIDTH] <= text_symbol; // Append at fill
		end
	end

endmodule

/* verilog/window_if.sv */
`timescale 1ns/1ns

interface window_if;

	string_match_pkg::window_t window;
	logic full;
	logic shift_strobe; // One cycle, drops shift_count oldest symbols
	string_match_pkg::shift_t shift_count;

	modport buffer (
		output window,
		output full,
		input shift_strobe,
		input shift_count
	);

	// The top routes window straight to the comparator
	modport scan (
		input full,
		output shift_strobe,
		output shift_count
	);

endinterface
